// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = lv_ctrl_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module lv_ctrl_top -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
verilog/lv_ctrl_pkg.sv
verilog/lv_pin_filter.sv
verilog/lv_err_collect.sv
verilog/lv_wdg_timer.sv
verilog/lv_fsm_ctrl.sv
verilog/lv_ctrl_top.sv
tests/lv_ctrl_tb.sv

// ==== tests/lv_ctrl_tb.sv ====
// lv_ctrl_tb
// random and directed stimulus for the lv control block checked against a model
`timescale 1ns/1ps

module lv_ctrl_tb
    import lv_ctrl_pkg::*;
();

    logic    clk = 1'b0;
    logic    rst_n = 1'b0;
    lv_pin_t pin = '0;
    lv_flt_t flt = '0;
    lv_cmd_t cmd = '0;
    logic    kick = 1'b0;
    logic    ld_done = 1'b0;
    logic    rx_ack = 1'b0;
    lv_en_t  en;
    logic    intb_n;
    logic    ef_req;
    logic    wd_req;
    lv_err_t err;
    lv_st_e  st;

    // model state
    lv_st_e  m_st = PWR_DWN_ST;
    lv_en_t  m_en = '0;
    logic    m_intb_n = 1'b0;
    logic    m_ef_req = 1'b0;
    logic    m_wd_req = 1'b0;
    lv_flt_t m_flt = '0;
    logic    m_wdg = 1'b0;
    int      m_cnt = 0;
    lv_pin_t hist [6];          // raw pin delay line with the filtered pin at [5]

    logic [31:0] seed = 32'd89;
    int errors = 0;
    int err_mark = 0;
    int n_pass = 0;
    int n_fail = 0;

    always #4 clk = ~clk;

    lv_ctrl_top dut (
        .i_clk (clk), .i_rst_n (rst_n), .i_pin (pin), .i_flt (flt), .i_cmd (cmd),
        .i_wdg_kick (kick), .i_efuse_load_done (ld_done), .i_owt_rx_ack (rx_ack),
        .o_en (en), .o_intb_n (intb_n), .o_efuse_load_req (ef_req),
        .o_wdg_owt_tx_req (wd_req), .o_err (err), .o_st (st)
    );

    function automatic logic [31:0] rnd();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {17'd0, seed[30:16]};
    endfunction

    task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // status image with summaries from the sticky flags
    function automatic lv_err_t err_image(input lv_flt_t f, input logic w);
        lv_err_t e;
        lv_flt_t s;
        s = f;
        s.pwm_dt = 1'b0;        // dead-time and overcurrent are not severe
        s.oc = 1'b0;
        e.flt = f;
        e.wdg_tmo = w;
        e.comm = f.owt_com | w;
        e.severe = e.comm | (|s);
        e.any = (|f) | w;
        return e;
    endfunction

    // ======================================================================
    // reference model for one clock edge
    // ======================================================================
    task automatic model_edge();
        lv_pin_t p;
        lv_err_t e;
        logic    tmo;
        lv_st_e  nx;
        p = hist[5];
        e = err_image(m_flt, m_wdg);
        nx = m_st;
        if (m_st != PWR_DWN_ST && !p.pwr_on) nx = PWR_DWN_ST;
        else case (m_st)
            PWR_DWN_ST: if (p.pwr_on) nx = WAIT_ST;
            WAIT_ST:
                if (p.test_mode || (ld_done && !cmd.efuse_vld)) nx = TEST_ST;
                else if (!e.comm && cmd.nml_en && cmd.efuse_vld)
                    nx = p.fsenb_n ? NML_ST : FAILSAFE_ST;
            TEST_ST: if (cmd.efuse_done && cmd.efuse_vld) nx = WAIT_ST;
            NML_ST, FAULT_ST:
                if (cmd.cfg_en) nx = CFG_ST;
                else if (!e.severe && !p.fsenb_n) nx = FAILSAFE_ST;
                else if (m_st == NML_ST && e.any) nx = FAULT_ST;
                else if (m_st == FAULT_ST && !e.any && p.fsenb_n) nx = NML_ST;
            FAILSAFE_ST:
                if (e.severe) nx = FAULT_ST;
                else if (p.fsenb_n) nx = NML_ST;
            CFG_ST:
                if (cmd.rst_en) nx = RST_ST;
                else if (cmd.cfg_en) nx = CFG_ST;
                else if (!e.severe && cmd.bist_en && p.fsenb_n) nx = BIST_ST;
                else if (!e.any) nx = p.fsenb_n ? NML_ST : FAILSAFE_ST;
                else nx = FAULT_ST;
            RST_ST: if (!cmd.rst_en) nx = WAIT_ST;
            BIST_ST: if (!cmd.bist_en) nx = CFG_ST;
            default: nx = PWR_DWN_ST;
        endcase
        // requests see the state before the edge
        if (ld_done) m_ef_req = 1'b0;
        else if (m_st == WAIT_ST && !p.test_mode && !cmd.efuse_vld) m_ef_req = 1'b1;
        if (rx_ack) m_wd_req = 1'b0;
        else if (m_st == WAIT_ST && !p.test_mode && cmd.efuse_vld && e.comm) m_wd_req = 1'b1;
        tmo = m_en.scan_en && !kick && m_cnt == WDG_TMO_CYC - 1;
        m_cnt = (m_en.scan_en && !kick && !tmo) ? m_cnt + 1 : 0;
        m_flt = cmd.err_clr ? flt : (m_flt | flt);
        m_wdg = cmd.err_clr ? tmo : (m_wdg | tmo);
        m_en.pwm_en = nx == NML_ST || (nx == FAULT_ST && !e.severe);
        m_en.fsc_en = nx == FAILSAFE_ST;
        m_en.scan_en = nx == NML_ST || nx == FAILSAFE_ST || nx == FAULT_ST;
        m_en.com_en = nx != PWR_DWN_ST;
        m_en.cfg_reg_en = nx == CFG_ST;
        m_en.test_reg_en = nx == TEST_ST;
        m_en.bist_en = nx == BIST_ST;
        m_intb_n = !(nx == PWR_DWN_ST || nx == WAIT_ST || nx == FAULT_ST || nx == RST_ST ||
                     (nx == CFG_ST && e.any));
        m_st = nx;
        for (int i = 5; i > 0; i--) hist[i] = hist[i-1];
        hist[0] = pin;
    endtask

    // one cycle of model edge and compare before the caller drives new inputs
    task automatic step();
        @(posedge clk);
        model_edge();
        #1;
        check("o_st", 32'(st), 32'(m_st));
        check("o_en", 32'(en), 32'(m_en));
        check("o_intb_n", 32'(intb_n), 32'(m_intb_n));
        check("o_efuse_load_req", 32'(ef_req), 32'(m_ef_req));
        check("o_wdg_owt_tx_req", 32'(wd_req), 32'(m_wd_req));
        check("o_err", 32'(err), 32'(err_image(m_flt, m_wdg)));
    endtask

    task automatic wait_st(input lv_st_e target, input int max_cyc);
        int n;
        n = 0;
        while (st != target && n < max_cyc) begin
            step();
            n++;
        end
        if (st != target) begin
            $display("Timeout at %0t: state %s never reached", $time, target.name());
            errors++;
        end
    endtask

    task automatic clear_err();
        cmd.err_clr = 1'b1;
        step();
        cmd.err_clr = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: fail, %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ======================================================================
    // tests
    // ======================================================================
    initial begin
        int gap;
        int hold;
        lv_flt_t bit_f;
        logic minor;
        for (int i = 0; i < 6; i++) hist[i] = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        // 1 power-up
        kick = 1'b1;
        pin = 3'b101;
        cmd.nml_en = 1'b1;
        cmd.efuse_vld = 1'b1;
        wait_st(WAIT_ST, 20);
        wait_st(NML_ST, 20);
        check("pwm_en", 32'(en.pwm_en), 1);
        check("scan_en", 32'(en.scan_en), 1);
        check("com_en", 32'(en.com_en), 1);
        check("intb_n", 32'(intb_n), 1);
        end_test("power_up");

        // 2 efuse load
        pin.pwr_on = 1'b0;
        wait_st(PWR_DWN_ST, 20);
        cmd = '0;
        pin.pwr_on = 1'b1;
        wait_st(WAIT_ST, 20);
        gap = 0;
        while (!ef_req && gap < 10) begin
            step();
            gap++;
        end
        if (!ef_req) begin
            $display("Timeout at %0t: efuse load request never rose", $time);
            errors++;
        end
        repeat (5) step();
        check("load req held", 32'(ef_req), 1);
        ld_done = 1'b1;
        step();
        ld_done = 1'b0;
        step();
        check("load req cleared", 32'(ef_req), 0);
        check("state after done", 32'(st), 32'(TEST_ST));
        check("test_reg_en", 32'(en.test_reg_en), 1);
        cmd.efuse_vld = 1'b1;
        cmd.efuse_done = 1'b1;
        wait_st(WAIT_ST, 10);
        cmd.efuse_done = 1'b0;
        end_test("efuse");

        // 3 faults in normal and fail-safe mode
        clear_err();
        cmd.nml_en = 1'b1;
        for (int r = 0; r < 12; r++) begin
            if (r == 6) pin.fsenb_n = 1'b0;
            clear_err();
            wait_st(r < 6 ? NML_ST : FAILSAFE_ST, 30);
            bit_f = lv_flt_t'(13'd1 << (rnd() % 13));
            flt = bit_f;
            step();
            flt = '0;
            step();
            check("sticky flag", 32'(err.flt), 32'(bit_f));
            minor = bit_f.pwm_dt || bit_f.oc;
            if (r < 6 || !minor) begin
                check("fault state", 32'(st), 32'(FAULT_ST));
                check("pwm_en in fault", 32'(en.pwm_en), 32'(minor));
            end else begin
                check("fail-safe kept", 32'(st), 32'(FAILSAFE_ST));
            end
        end
        pin.fsenb_n = 1'b1;
        clear_err();
        wait_st(NML_ST, 30);
        end_test("faults");

        // 4 watchdog
        kick = 1'b0;
        gap = 1 + rnd() % 60;
        for (int c = 0; c < 300; c++) begin
            kick = (gap == 0);
            gap = (gap == 0) ? 1 + rnd() % 60 : gap - 1;
            step();
        end
        check("no wdg timeout", 32'(err.wdg_tmo), 0);
        kick = 1'b0;
        wait_st(FAULT_ST, 100);
        check("wdg flag", 32'(err.wdg_tmo), 1);
        check("intb_n in fault", 32'(intb_n), 0);
        end_test("watchdog");

        // 5 config, bist, reset and power-down
        kick = 1'b1;
        clear_err();
        cmd.cfg_en = 1'b1;
        wait_st(CFG_ST, 10);
        check("cfg_reg_en", 32'(en.cfg_reg_en), 1);
        cmd.cfg_en = 1'b0;
        cmd.bist_en = 1'b1;
        wait_st(BIST_ST, 10);
        check("bist_en", 32'(en.bist_en), 1);
        cmd.bist_en = 1'b0;
        cmd.cfg_en = 1'b1;
        wait_st(CFG_ST, 10);
        cmd.rst_en = 1'b1;
        wait_st(RST_ST, 10);
        cmd.rst_en = 1'b0;
        cmd.cfg_en = 1'b0;
        wait_st(WAIT_ST, 10);
        pin.pwr_on = 1'b0;
        wait_st(PWR_DWN_ST, 20);
        end_test("config");

        // 6 random soak with levels held 8 to 15 cycles
        hold = 0;
        for (int c = 0; c < 3000; c++) begin
            if (hold == 0) begin
                hold = 8 + rnd() % 8;
                pin = lv_pin_t'(rnd());
                pin.pwr_on = (rnd() % 8) != 0;
                pin.test_mode = (rnd() % 6) == 0;
                cmd = lv_cmd_t'(rnd());
                cmd.rst_en = (rnd() % 5) == 0;
            end
            hold--;
            cmd.err_clr = (rnd() % 20) == 0;
            flt = ((rnd() % 16) == 0) ? lv_flt_t'(13'd1 << (rnd() % 13)) : '0;
            kick = (rnd() % 24) != 0;
            ld_done = (rnd() % 16) == 0;
            rx_ack = (rnd() % 16) == 0;
            step();
        end
        end_test("soak");

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/lv_ctrl_pkg.sv ====
// lv_ctrl_pkg
// shared state encoding, status structs and timing constants of the
// low-voltage control block
package lv_ctrl_pkg;

    // ======================================================================
    // timing
    // ======================================================================
    localparam int FILT_CYC    = 4;    // cycles a synced pin must hold
    localparam int WDG_TMO_CYC = 64;   // cycles without kick before timeout

    localparam int FILT_CW = $clog2(FILT_CYC);
    localparam int WDG_CW  = $clog2(WDG_TMO_CYC);

    // ======================================================================
    // mode states
    // ======================================================================
    typedef enum logic [3:0] {
        PWR_DWN_ST  = 4'd0,
        WAIT_ST     = 4'd1,
        TEST_ST     = 4'd2,
        NML_ST      = 4'd3,
        FAILSAFE_ST = 4'd4,
        FAULT_ST    = 4'd5,
        CFG_ST      = 4'd6,
        RST_ST      = 4'd7,
        BIST_ST     = 4'd8
    } lv_st_e;

    // ======================================================================
    // status and control bundles
    // ======================================================================
    typedef struct packed {
        logic pwr_on;
        logic test_mode;
        logic fsenb_n;     // fail-safe enable, active low
    } lv_pin_t;

    // raw fault sources, lv side first then hv side
    typedef struct packed {
        logic owt_com;
        logic spi;
        logic scan_crc;
        logic pwm_dt;
        logic pwm_mm;
        logic vsup_uv;
        logic vsup_ov;
        logic vcc_uv;
        logic vcc_ov;
        logic ot;
        logic oc;
        logic desat;
        logic scp;
    } lv_flt_t;

    typedef struct packed {
        lv_flt_t flt;      // sticky copy of the sources
        logic    wdg_tmo;
        logic    comm;     // link lost
        logic    severe;   // blocks pwm in fault
        logic    any;
    } lv_err_t;

    typedef struct packed {
        logic nml_en;
        logic cfg_en;
        logic bist_en;
        logic rst_en;
        logic efuse_vld;
        logic efuse_done;
        logic err_clr;     // strobe
    } lv_cmd_t;

    typedef struct packed {
        logic pwm_en;
        logic fsc_en;
        logic scan_en;
        logic com_en;
        logic cfg_reg_en;
        logic test_reg_en;
        logic bist_en;
    } lv_en_t;

endpackage

// ==== verilog/lv_ctrl_top.sv ====
// lv_ctrl_top
// low-voltage control block, pin filter, fault collector, watchdog and FSM
`timescale 1ns/1ps

module lv_ctrl_top
    import lv_ctrl_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  lv_pin_t i_pin,
    input  lv_flt_t i_flt,
    input  lv_cmd_t i_cmd,
    input  logic    i_wdg_kick,
    input  logic    i_efuse_load_done,
    input  logic    i_owt_rx_ack,
    output lv_en_t  o_en,
    output logic    o_intb_n,
    output logic    o_efuse_load_req,
    output logic    o_wdg_owt_tx_req,
    output lv_err_t o_err,
    output lv_st_e  o_st
);

    lv_pin_t pin_filt;
    logic    wdg_tmo;

    lv_pin_filter u_pin_filter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_pin   (i_pin),
        .o_pin   (pin_filt)
    );

    lv_err_collect u_err_collect (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_flt     (i_flt),
        .i_wdg_tmo (wdg_tmo),
        .i_err_clr (i_cmd.err_clr),
        .o_err     (o_err)
    );

    lv_wdg_timer u_wdg_timer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_scan_en (o_en.scan_en),     // runs only in the active modes
        .i_kick    (i_wdg_kick),
        .o_tmo     (wdg_tmo)
    );

    lv_fsm_ctrl u_fsm_ctrl (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_pin             (pin_filt),
        .i_err             (o_err),
        .i_cmd             (i_cmd),
        .i_efuse_load_done (i_efuse_load_done),
        .i_owt_rx_ack      (i_owt_rx_ack),
        .o_en              (o_en),
        .o_intb_n          (o_intb_n),
        .o_efuse_load_req  (o_efuse_load_req),
        .o_wdg_owt_tx_req  (o_wdg_owt_tx_req),
        .o_st              (o_st)
    );

endmodule

// ==== verilog/lv_err_collect.sv ====
// lv_err_collect
// latches raw fault flags into sticky status bits and builds the summaries
`timescale 1ns/1ps

module lv_err_collect
    import lv_ctrl_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  lv_flt_t i_flt,
    input  logic    i_wdg_tmo,
    input  logic    i_err_clr,
    output lv_err_t o_err
);

    lv_flt_t flt_q;
    logic    wdg_q;
    logic    comm;
    logic    severe;
    logic    any_err;

    // ======================================================================
    // sticky bits, a source active during clear still sets
    // ======================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            flt_q <= '0;
            wdg_q <= 1'b0;
        end else if (i_err_clr) begin
            flt_q <= i_flt;
            wdg_q <= i_wdg_tmo;
        end else begin
            flt_q <= flt_q | i_flt;
            wdg_q <= wdg_q | i_wdg_tmo;
        end
    end

    // ======================================================================
    // summaries
    // ======================================================================
    assign comm = flt_q.owt_com | wdg_q;

    // dead-time and overcurrent still allow pwm
    assign severe = comm
                  | flt_q.spi    | flt_q.scan_crc
                  | flt_q.pwm_mm
                  | flt_q.vsup_uv | flt_q.vsup_ov
                  | flt_q.vcc_uv  | flt_q.vcc_ov
                  | flt_q.ot
                  | flt_q.desat  | flt_q.scp;

    assign any_err = (|flt_q) | wdg_q;

    always_comb begin
        o_err.flt     = flt_q;
        o_err.wdg_tmo = wdg_q;
        o_err.comm    = comm;
        o_err.severe  = severe;
        o_err.any     = any_err;
    end

endmodule

// ==== verilog/lv_fsm_ctrl.sv ====
// lv_fsm_ctrl
// mode state machine of the lv side, drives the block enables, the
// interrupt pin and the efuse load and watchdog report requests
`timescale 1ns/1ps

module lv_fsm_ctrl
    import lv_ctrl_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  lv_pin_t i_pin,
    input  lv_err_t i_err,
    input  lv_cmd_t i_cmd,
    input  logic    i_efuse_load_done,   // hw load finished
    input  logic    i_owt_rx_ack,
    output lv_en_t  o_en,
    output logic    o_intb_n,
    output logic    o_efuse_load_req,
    output logic    o_wdg_owt_tx_req,
    output lv_st_e  o_st
);

    lv_st_e st_q;
    lv_st_e st_nxt;
    lv_en_t en_nxt;
    logic   intb_nxt_n;
    logic   wait_run;

    // ======================================================================
    // next state
    // ======================================================================
    always_comb begin
        st_nxt = st_q;
        if (st_q != PWR_DWN_ST && !i_pin.pwr_on) begin
            st_nxt = PWR_DWN_ST;               // supply lost
        end else begin
            case (st_q)
                PWR_DWN_ST: begin
                    if (i_pin.pwr_on) begin
                        st_nxt = WAIT_ST;
                    end
                end
                WAIT_ST: begin
                    if (i_pin.test_mode ||
                        (i_efuse_load_done && !i_cmd.efuse_vld)) begin
                        st_nxt = TEST_ST;
                    end else if (!i_err.comm && i_cmd.nml_en && i_cmd.efuse_vld) begin
                        st_nxt = i_pin.fsenb_n ? NML_ST : FAILSAFE_ST;
                    end
                end
                TEST_ST: begin
                    if (i_cmd.efuse_done && i_cmd.efuse_vld) begin
                        st_nxt = WAIT_ST;
                    end
                end
                NML_ST: begin
                    if (i_cmd.cfg_en) begin
                        st_nxt = CFG_ST;
                    end else if (!i_err.severe && !i_pin.fsenb_n) begin
                        st_nxt = FAILSAFE_ST;
                    end else if (i_err.any) begin
                        st_nxt = FAULT_ST;
                    end
                end
                FAILSAFE_ST: begin
                    if (i_err.severe) begin
                        st_nxt = FAULT_ST;
                    end else if (i_pin.fsenb_n) begin
                        st_nxt = NML_ST;
                    end
                end
                FAULT_ST: begin
                    if (i_cmd.cfg_en) begin
                        st_nxt = CFG_ST;
                    end else if (!i_err.severe && !i_pin.fsenb_n) begin
                        st_nxt = FAILSAFE_ST;
                    end else if (!i_err.any && i_pin.fsenb_n) begin
                        st_nxt = NML_ST;
                    end
                end
                CFG_ST: begin
                    if (i_cmd.rst_en) begin
                        st_nxt = RST_ST;
                    end else if (i_cmd.cfg_en) begin
                        st_nxt = CFG_ST;           // still configuring
                    end else if (!i_err.severe && i_cmd.bist_en && i_pin.fsenb_n) begin
                        st_nxt = BIST_ST;
                    end else if (!i_err.any) begin
                        st_nxt = i_pin.fsenb_n ? NML_ST : FAILSAFE_ST;
                    end else begin
                        st_nxt = FAULT_ST;
                    end
                end
                RST_ST: begin
                    if (!i_cmd.rst_en) begin
                        st_nxt = WAIT_ST;
                    end
                end
                BIST_ST: begin
                    if (!i_cmd.bist_en) begin
                        st_nxt = CFG_ST;
                    end
                end
                default: begin
                    st_nxt = PWR_DWN_ST;
                end
            endcase
        end
    end

    // ======================================================================
    // enables and interrupt, decoded from the next state
    // ======================================================================
    always_comb begin
        en_nxt.pwm_en      = (st_nxt == NML_ST) ||
                             (st_nxt == FAULT_ST && !i_err.severe);
        en_nxt.fsc_en      = (st_nxt == FAILSAFE_ST);
        en_nxt.scan_en     = st_nxt inside {NML_ST, FAILSAFE_ST, FAULT_ST};
        en_nxt.com_en      = (st_nxt != PWR_DWN_ST);
        en_nxt.cfg_reg_en  = (st_nxt == CFG_ST);
        en_nxt.test_reg_en = (st_nxt == TEST_ST);
        en_nxt.bist_en     = (st_nxt == BIST_ST);

        intb_nxt_n = !((st_nxt inside {PWR_DWN_ST, WAIT_ST, FAULT_ST, RST_ST}) ||
                       (st_nxt == CFG_ST && i_err.any));
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            st_q     <= PWR_DWN_ST;
            o_en     <= '0;
            o_intb_n <= 1'b0;          // asserted while powered down
        end else begin
            st_q     <= st_nxt;
            o_en     <= en_nxt;
            o_intb_n <= intb_nxt_n;
        end
    end

    assign o_st = st_q;

    // ======================================================================
    // requests, held until done or ack
    // ======================================================================
    assign wait_run = (st_q == WAIT_ST) && !i_pin.test_mode;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_efuse_load_req <= 1'b0;
        end else if (i_efuse_load_done) begin
            o_efuse_load_req <= 1'b0;
        end else if (wait_run && !i_cmd.efuse_vld) begin
            o_efuse_load_req <= 1'b1;  // fuses not loaded yet
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wdg_owt_tx_req <= 1'b0;
        end else if (i_owt_rx_ack) begin
            o_wdg_owt_tx_req <= 1'b0;
        end else if (wait_run && i_cmd.efuse_vld && i_err.comm) begin
            o_wdg_owt_tx_req <= 1'b1;  // report link loss over one-wire
        end
    end

endmodule

// ==== verilog/lv_pin_filter.sv ====
// lv_pin_filter
// synchronizes the mode pins and accepts a new level only once it is stable
`timescale 1ns/1ps

module lv_pin_filter
    import lv_ctrl_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  lv_pin_t i_pin,
    output lv_pin_t o_pin
);

    localparam int NPIN = $bits(lv_pin_t);

    logic [NPIN-1:0]    sync1_q;
    logic [NPIN-1:0]    sync2_q;
    logic [NPIN-1:0]    pin_q;
    logic [FILT_CW-1:0] cnt_q [NPIN];

    // two-flop synchronizer
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= i_pin;
            sync2_q <= sync1_q;
        end
    end

    // stability counter per pin
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pin_q <= '0;
            for (int i = 0; i < NPIN; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NPIN; i++) begin
                if (sync2_q[i] == pin_q[i]) begin
                    cnt_q[i] <= '0;                // no change pending
                end else if (cnt_q[i] == FILT_CW'(FILT_CYC - 1)) begin
                    pin_q[i] <= sync2_q[i];        // held long enough
                    cnt_q[i] <= '0;
                end else begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign o_pin = lv_pin_t'(pin_q);

endmodule

// ==== verilog/lv_wdg_timer.sv ====
// lv_wdg_timer
// communication watchdog, times out when no kick arrives while scanning
`timescale 1ns/1ps

module lv_wdg_timer
    import lv_ctrl_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_scan_en,
    input  logic i_kick,
    output logic o_tmo
);

    localparam logic [WDG_CW-1:0] CNT_MAX = WDG_CW'(WDG_TMO_CYC - 1);

    logic [WDG_CW-1:0] cnt_q;
    logic              cnt_run;
    logic              cnt_end;

    assign cnt_run = i_scan_en & ~i_kick;
    assign cnt_end = (cnt_q == CNT_MAX);

    // ======================================================================
    // counter
    // ======================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (!cnt_run) begin
            cnt_q <= '0;               // kicked or idle
        end else if (cnt_end) begin
            cnt_q <= '0;               // restart after timeout
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // one cycle wide, counter restarts on the same edge
    assign o_tmo = cnt_run & cnt_end;

endmodule
